// ==== src/dmm_pkg.sv ====
// shared widths, register map, mode and state encodings
// packed structs for acquisition config, sequencer result and pin vector

`default_nettype none

package dmm_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // widths

  localparam int REG_W     = 32;   // spi data word
  localparam int ADDR_W    = 8;    // spi address
  localparam int XFER_BITS = ADDR_W + REG_W;  // full write transaction
  localparam int BITCNT_W  = 6;    // holds 0..63, saturates
  localparam int CNT_W     = 24;   // precharge / aperture clk counts
  localparam int AZMUX_W   = 4;
  localparam int PC_W      = 2;
  localparam int MODE_W    = 3;
  localparam int ST_W      = 3;
  localparam int FLAGS_W   = 4;
  localparam int MAGIC_W   = 8;
  localparam int LED_W     = 4;
  localparam int MON_W     = 8;
  localparam int OUT_W     = 20;   // whole pin vector

  typedef logic [REG_W-1:0]   reg_word_t;
  typedef logic [ADDR_W-1:0]  reg_addr_t;
  typedef logic [CNT_W-1:0]   clk_count_t;
  typedef logic [AZMUX_W-1:0] azmux_t;
  typedef logic [PC_W-1:0]    pc_sw_t;

  ////////////////////////////////////////////////////////////////////////////
  // register map

  localparam reg_addr_t REG_STATUS       = 8'h00;  // ro
  localparam reg_addr_t REG_MODE         = 8'h01;
  localparam reg_addr_t REG_DIRECT       = 8'h02;
  localparam reg_addr_t REG_ARM          = 8'h03;
  localparam reg_addr_t REG_PRECHARGE    = 8'h04;
  localparam reg_addr_t REG_AZMUX_LO     = 8'h05;
  localparam reg_addr_t REG_AZMUX_HI     = 8'h06;
  localparam reg_addr_t REG_PC_HI        = 8'h07;
  localparam reg_addr_t REG_APERTURE     = 8'h08;
  localparam reg_addr_t REG_SAMPLE_COUNT = 8'h09;  // ro

  localparam logic [MAGIC_W-1:0] STATUS_MAGIC = 8'hAA;

  // output mode, codes 4..7 park all pins low
  typedef enum logic [MODE_W-1:0] {
    MODE_DIRECT = 3'd0,
    MODE_LO     = 3'd1,
    MODE_HI     = 3'd2,
    MODE_AZ     = 3'd3
  } mode_t;

  typedef enum logic [ST_W-1:0] {
    AZ_IDLE      = 3'd0,
    AZ_PRECHARGE = 3'd1,
    AZ_SAMPLE_HI = 3'd2,
    AZ_SAMPLE_LO = 3'd3
  } az_state_t;

  ////////////////////////////////////////////////////////////////////////////
  // structs

  // msb first, so leds land at bit 0
  typedef struct packed {
    logic               meas_complete;  // 19
    logic               spi_interrupt;  // 18
    azmux_t             azmux;          // 17..14
    pc_sw_t             pc_sw;          // 13..12
    logic [MON_W-1:0]   monitor;        // 11..4
    logic [LED_W-1:0]   leds;           // 3..0
  } pins_t;

  typedef struct packed {
    logic       arm;
    clk_count_t precharge;
    azmux_t     azmux_lo;
    azmux_t     azmux_hi;
    pc_sw_t     pc_hi;
    clk_count_t aperture;
  } acq_cfg_t;

  typedef struct packed {
    az_state_t state;
    azmux_t    azmux;
    pc_sw_t    pc_sw;
    logic      trig;
    logic      meas_valid;
  } az_result_t;

endpackage

`default_nettype wire

// ==== src/spi_reg_decode.sv ====
// spi slave on the system clock, mode 0, msb first
// 8 addr bits then 32 data bits, register bank with readback and sample count

`default_nettype none

module spi_reg_decode (
  input  logic                          clk,
  input  logic                          rst_n_i,
  input  logic                          sck_i,
  input  logic                          ss_n_i,
  input  logic                          sdi_i,
  input  logic [dmm_pkg::FLAGS_W-1:0]   hw_flags_i,
  input  logic                          meas_valid_i,
  output logic                          sdo_o,
  output dmm_pkg::acq_cfg_t             cfg_o,
  output dmm_pkg::mode_t                mode_o,
  output dmm_pkg::pins_t                direct_o
);
  import dmm_pkg::*;

  logic [2:0]          meta_q;      // {sck, ss_n, sdi}
  logic [2:0]          sync_q;
  logic                sck_prev_q;
  logic                ss_prev_q;
  logic                sck_s;
  logic                ss_s;
  logic                sdi_s;
  logic                sck_rise;
  logic                sck_fall;
  logic                ss_rise;
  logic [BITCNT_W-1:0] bit_cnt_q;
  reg_addr_t           addr_q;
  reg_addr_t           addr_nxt;
  reg_word_t           data_q;
  reg_word_t           tx_q;
  reg_word_t           rd_word;
  logic                commit_q;
  logic                wr_en;
  mode_t               mode_q;
  pins_t               direct_q;
  acq_cfg_t            cfg_q;
  reg_word_t           sample_cnt_q;

  ////////////////////////////////////////////////////////////////////////////
  // pin synchronizers and edge detect

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      meta_q     <= 3'b010;   // ss_n idles high
      sync_q     <= 3'b010;
      sck_prev_q <= 1'b0;
      ss_prev_q  <= 1'b1;
    end else begin
      meta_q     <= {sck_i, ss_n_i, sdi_i};
      sync_q     <= meta_q;
      sck_prev_q <= sck_s;
      ss_prev_q  <= ss_s;
    end
  end

  assign sck_s    = sync_q[2];
  assign ss_s     = sync_q[1];
  assign sdi_s    = sync_q[0];
  assign sck_rise = sck_s & ~sck_prev_q;
  assign sck_fall = ~sck_s & sck_prev_q;
  assign ss_rise  = ss_s & ~ss_prev_q;

  assign addr_nxt = {addr_q[ADDR_W-2:0], sdi_s};  // addr incl. bit being sampled

  ////////////////////////////////////////////////////////////////////////////
  // bit count and shift out

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      bit_cnt_q <= '0;
      tx_q      <= '0;
    end else if (ss_s) begin      // deselected
      bit_cnt_q <= '0;
      tx_q      <= '0;              // sdo parks low
    end else if (sck_rise) begin
      if (bit_cnt_q != '1) begin
        bit_cnt_q <= bit_cnt_q + 1'b1;
      end
      if (bit_cnt_q == BITCNT_W'(ADDR_W - 1)) begin
        tx_q <= rd_word;            // preload on last addr bit
      end
    end else if (sck_fall && bit_cnt_q > BITCNT_W'(ADDR_W)) begin
      tx_q <= {tx_q[REG_W-2:0], 1'b0};  // msb held through first data edge
    end
  end

  assign sdo_o = tx_q[REG_W-1];

  // receive shifters
  always_ff @(posedge clk) begin
    if (!ss_s && sck_rise) begin
      if (bit_cnt_q < BITCNT_W'(ADDR_W)) begin
        addr_q <= addr_nxt;
      end else begin
        data_q <= {data_q[REG_W-2:0], sdi_s};
      end
    end
  end

  // commit one cycle after deselect, only on a full 40 bit frame
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      commit_q <= 1'b0;
    end else begin
      commit_q <= ss_rise && (bit_cnt_q == BITCNT_W'(XFER_BITS));
    end
  end

  assign wr_en = commit_q && (addr_q inside {[REG_MODE:REG_APERTURE]});

  ////////////////////////////////////////////////////////////////////////////
  // register bank

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      mode_q   <= MODE_DIRECT;
      direct_q <= '0;
      cfg_q    <= '0;
    end else if (wr_en) begin
      case (addr_q)
        REG_MODE:      mode_q         <= mode_t'(data_q[MODE_W-1:0]);
        REG_DIRECT:    direct_q       <= pins_t'(data_q[OUT_W-1:0]);
        REG_ARM:       cfg_q.arm      <= data_q[0];
        REG_PRECHARGE: cfg_q.precharge <= data_q[CNT_W-1:0];
        REG_AZMUX_LO:  cfg_q.azmux_lo <= data_q[AZMUX_W-1:0];
        REG_AZMUX_HI:  cfg_q.azmux_hi <= data_q[AZMUX_W-1:0];
        REG_PC_HI:     cfg_q.pc_hi    <= data_q[PC_W-1:0];
        REG_APERTURE:  cfg_q.aperture <= data_q[CNT_W-1:0];
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sample_cnt_q <= '0;
    end else if (meas_valid_i) begin
      sample_cnt_q <= sample_cnt_q + 1'b1;   // one per completed sample
    end
  end

  // readback, zero extended, unknown addr reads 0
  always_comb begin
    rd_word = '0;
    case (addr_nxt)
      REG_STATUS: begin
        rd_word[MAGIC_W-1:0]       = STATUS_MAGIC;
        rd_word[MAGIC_W +: FLAGS_W] = hw_flags_i;
      end
      REG_MODE:         rd_word[MODE_W-1:0]  = mode_q;
      REG_DIRECT:       rd_word[OUT_W-1:0]   = direct_q;
      REG_ARM:          rd_word[0]           = cfg_q.arm;
      REG_PRECHARGE:    rd_word[CNT_W-1:0]   = cfg_q.precharge;
      REG_AZMUX_LO:     rd_word[AZMUX_W-1:0] = cfg_q.azmux_lo;
      REG_AZMUX_HI:     rd_word[AZMUX_W-1:0] = cfg_q.azmux_hi;
      REG_PC_HI:        rd_word[PC_W-1:0]    = cfg_q.pc_hi;
      REG_APERTURE:     rd_word[CNT_W-1:0]   = cfg_q.aperture;
      REG_SAMPLE_COUNT: rd_word              = sample_cnt_q;
      default: ;
    endcase
  end

  assign cfg_o    = cfg_q;
  assign mode_o   = mode_q;
  assign direct_o = direct_q;

  // bank contents move only after a deselect that closed a full frame
  a_wr_after_ss_rise: assert property (@(posedge clk) disable iff (!rst_n_i)
    ((mode_q != $past(mode_q)) || (direct_q != $past(direct_q)) || (cfg_q != $past(cfg_q)))
    |-> $past(ss_rise, 2) && ($past(bit_cnt_q, 2) == BITCNT_W'(XFER_BITS)));

endmodule

`default_nettype wire

// ==== src/adc_mock.sv ====
// stand-in adc, times the aperture after each trigger
// pulses meas_valid exactly aperture cycles after trig

`default_nettype none

module adc_mock (
  input  logic                clk,
  input  logic                rst_n_i,
  input  logic                trig_i,
  input  dmm_pkg::clk_count_t aperture_i,
  output logic                meas_valid_o,
  output logic                busy_o
);
  import dmm_pkg::*;

  clk_count_t cnt_q;     // cycles left in aperture
  logic       busy_q;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_q <= 1'b0;
      cnt_q  <= '0;
    end else if (trig_i) begin
      busy_q <= 1'b1;
      cnt_q  <= (aperture_i == '0) ? clk_count_t'(1) : aperture_i;  // 0 acts as 1
    end else if (busy_q) begin
      if (cnt_q == clk_count_t'(1)) begin
        busy_q <= 1'b0;      // last cycle, valid shows now
      end else begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  assign meas_valid_o = busy_q && (cnt_q == clk_count_t'(1));
  assign busy_o       = busy_q;

  // one sample in flight at a time
  a_no_trig_busy: assert property (@(posedge clk) disable iff (!rst_n_i)
    trig_i |-> !busy_q);

endmodule

`default_nettype wire

// ==== src/az_sequencer.sv ====
// auto-zero acquisition fsm, precharge then alternating hi / lo samples
// drives azmux and precharge switch codes, triggers the mock adc

`default_nettype none

module az_sequencer (
  input  logic                clk,
  input  logic                rst_n_i,
  input  dmm_pkg::acq_cfg_t   cfg_i,
  output dmm_pkg::az_result_t res_o
);
  import dmm_pkg::*;

  az_state_t  state_q;
  az_state_t  state_d;
  clk_count_t pc_cnt_q;   // precharge cycles left
  azmux_t     azmux_q;
  pc_sw_t     pc_sw_q;
  logic       trig_q;
  logic       meas_valid;
  logic       adc_busy;

  adc_mock adc_mock_i (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .trig_i       (trig_q),
    .aperture_i   (cfg_i.aperture),
    .meas_valid_o (meas_valid),
    .busy_o       (adc_busy)
  );

  ////////////////////////////////////////////////////////////////////////////
  // next state

  always_comb begin
    state_d = state_q;
    case (state_q)
      AZ_IDLE:      if (cfg_i.arm) state_d = AZ_PRECHARGE;
      AZ_PRECHARGE: if (pc_cnt_q <= clk_count_t'(1)) state_d = AZ_SAMPLE_HI;
      AZ_SAMPLE_HI: if (meas_valid) state_d = AZ_SAMPLE_LO;
      AZ_SAMPLE_LO: begin
        if (meas_valid) begin
          state_d = cfg_i.arm ? AZ_SAMPLE_HI : AZ_IDLE;  // disarm finishes lo first
        end
      end
      default:      state_d = AZ_IDLE;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // state and entry actions, cfg sampled on entry only

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q  <= AZ_IDLE;
      pc_cnt_q <= '0;
      azmux_q  <= '0;
      pc_sw_q  <= '0;
      trig_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      trig_q  <= 1'b0;                  // single cycle pulse
      if (state_q == AZ_PRECHARGE) begin
        pc_cnt_q <= pc_cnt_q - 1'b1;
      end
      if (state_d != state_q) begin
        case (state_d)
          AZ_PRECHARGE: begin
            pc_cnt_q <= cfg_i.precharge;
            azmux_q  <= cfg_i.azmux_hi;
            pc_sw_q  <= '0;             // precharge switch off
          end
          AZ_SAMPLE_HI: begin
            azmux_q <= cfg_i.azmux_hi;
            pc_sw_q <= cfg_i.pc_hi;
            trig_q  <= 1'b1;
          end
          AZ_SAMPLE_LO: begin
            azmux_q <= cfg_i.azmux_lo;
            pc_sw_q <= cfg_i.pc_hi;
            trig_q  <= 1'b1;
          end
          default: begin                // back to idle
            azmux_q <= '0;
            pc_sw_q <= '0;
          end
        endcase
      end
    end
  end

  always_comb begin
    res_o.state      = state_q;
    res_o.azmux      = azmux_q;
    res_o.pc_sw      = pc_sw_q;
    res_o.trig       = trig_q;
    res_o.meas_valid = meas_valid;
  end

  // mux and precharge switch hold still while a sample is in flight
  a_azmux_hold_in_sample: assert property (@(posedge clk) disable iff (!rst_n_i)
    adc_busy |-> $stable(azmux_q) && $stable(pc_sw_q));

  // adc stays busy for the whole sample once triggered
  a_adc_busy_in_sample: assert property (@(posedge clk) disable iff (!rst_n_i)
    (state_q inside {AZ_SAMPLE_HI, AZ_SAMPLE_LO}) && !trig_q |-> adc_busy);

endmodule

`default_nettype wire

// ==== src/output_mode_mux.sv ====
// output mode select, direct / all low / all high / az acquisition
// registered, pins follow their source one cycle later

`default_nettype none

module output_mode_mux (
  input  logic                clk,
  input  logic                rst_n_i,
  input  dmm_pkg::mode_t      mode_i,
  input  dmm_pkg::pins_t      direct_i,
  input  dmm_pkg::az_result_t res_i,
  output dmm_pkg::pins_t      pins_o
);
  import dmm_pkg::*;

  pins_t az_pins;
  pins_t pins_d;
  pins_t pins_q;

  // az mode pin vector
  always_comb begin
    az_pins               = '0;
    az_pins.leds[0]       = (res_i.state != AZ_IDLE);  // acquisition running
    az_pins.monitor[ST_W-1:0] = res_i.state;
    az_pins.pc_sw         = res_i.pc_sw;
    az_pins.azmux         = res_i.azmux;
    az_pins.spi_interrupt = res_i.meas_valid;   // host irq per sample
    az_pins.meas_complete = res_i.meas_valid;
  end

  always_comb begin
    case (mode_i)
      MODE_DIRECT: pins_d = direct_i;
      MODE_LO:     pins_d = '0;
      MODE_HI:     pins_d = '1;
      MODE_AZ:     pins_d = az_pins;
      default:     pins_d = '0;    // undefined codes park low
    endcase
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pins_q <= '0;
    end else begin
      pins_q <= pins_d;
    end
  end

  assign pins_o = pins_q;

endmodule

`default_nettype wire

// ==== src/dmm_fpga_top.sv ====
// dmm front-end control core top level
// spi register decode, az sequencer with mock adc, output mode mux

`default_nettype none

module dmm_fpga_top (
  input  logic                         clk,
  input  logic                         rst_n_i,

  // spi slave
  input  logic                         sck_i,
  input  logic                         ss_n_i,
  input  logic                         sdi_i,
  output logic                         sdo_o,

  input  logic [dmm_pkg::FLAGS_W-1:0]  hw_flags_i,

  // board pins
  output logic [dmm_pkg::LED_W-1:0]    leds_o,
  output logic [dmm_pkg::MON_W-1:0]    monitor_o,
  output logic [dmm_pkg::PC_W-1:0]     pc_sw_o,
  output logic [dmm_pkg::AZMUX_W-1:0]  azmux_o,
  output logic                         spi_interrupt_o,
  output logic                         meas_complete_o
);
  import dmm_pkg::*;

  acq_cfg_t   cfg;
  mode_t      mode;
  pins_t      direct;
  az_result_t az_res;
  pins_t      pins;

  ////////////////////////////////////////////////////////////////////////////
  // decode

  spi_reg_decode spi_reg_decode_i (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .sck_i        (sck_i),
    .ss_n_i       (ss_n_i),
    .sdi_i        (sdi_i),
    .hw_flags_i   (hw_flags_i),
    .meas_valid_i (az_res.meas_valid),   // sample count feedback
    .sdo_o        (sdo_o),
    .cfg_o        (cfg),
    .mode_o       (mode),
    .direct_o     (direct)
  );

  // execute
  az_sequencer az_sequencer_i (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .cfg_i   (cfg),
    .res_o   (az_res)
  );

  // result
  output_mode_mux output_mode_mux_i (
    .clk      (clk),
    .rst_n_i  (rst_n_i),
    .mode_i   (mode),
    .direct_i (direct),
    .res_i    (az_res),
    .pins_o   (pins)
  );

  ////////////////////////////////////////////////////////////////////////////
  // pin split

  assign leds_o          = pins.leds;
  assign monitor_o       = pins.monitor;
  assign pc_sw_o         = pins.pc_sw;
  assign azmux_o         = pins.azmux;
  assign spi_interrupt_o = pins.spi_interrupt;
  assign meas_complete_o = pins.meas_complete;

endmodule

`default_nettype wire

// ==== verification/tb_dmm_top.sv ====
// testbench for the dmm control core top level
// spi host tasks, register and pin reference model, az acquisition monitor

`default_nettype none

module tb_dmm_top;
  import dmm_pkg::*;

  localparam int HALF_SCK  = 4;    // clk cycles per sck half period
  localparam int N_XFER    = 39;   // spi transactions in the whole run
  localparam int N_AZ      = 2;    // acquisition run and disarm
  localparam int WDOG_TIME = N_XFER * 40 * 64 + N_AZ * 2000 * 8 + 20 * 8;
  localparam int N_SAMPLES = 6;

  logic        clk;
  logic        rst_n_i;
  logic        sck_i;
  logic        ss_n_i;
  logic        sdi_i;
  logic [3:0]  hw_flags_i;
  logic        sdo_o;
  logic [3:0]  leds_o;
  logic [7:0]  monitor_o;
  logic [1:0]  pc_sw_o;
  logic [3:0]  azmux_o;
  logic        spi_interrupt_o;
  logic        meas_complete_o;
  logic [19:0] pins_obs;

  integer    seed = 32'h03a67725;
  int        err_cnt = 0;
  int        chk_cnt = 0;
  int        pulse_cnt = 0;     // meas_complete pulses seen on the pins
  int        gap_cnt = 0;
  logic      seen_pulse = 1'b0;
  logic      az_mon_en = 1'b0;
  logic [2:0] prev_st = 3'd0;
  reg_word_t model [0:255];     // register model, indexed by address

  dmm_fpga_top dmm_fpga_top_i (
    .clk             (clk),
    .rst_n_i         (rst_n_i),
    .sck_i           (sck_i),
    .ss_n_i          (ss_n_i),
    .sdi_i           (sdi_i),
    .sdo_o           (sdo_o),
    .hw_flags_i      (hw_flags_i),
    .leds_o          (leds_o),
    .monitor_o       (monitor_o),
    .pc_sw_o         (pc_sw_o),
    .azmux_o         (azmux_o),
    .spi_interrupt_o (spi_interrupt_o),
    .meas_complete_o (meas_complete_o)
  );

  assign pins_obs = {meas_complete_o, spi_interrupt_o, azmux_o, pc_sw_o, monitor_o, leds_o};

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // reference model

  function automatic reg_word_t field_mask(input reg_addr_t addr);
    case (addr)
      REG_MODE:                   return 32'h0000_0007;
      REG_DIRECT:                 return 32'h000F_FFFF;
      REG_ARM:                    return 32'h0000_0001;
      REG_PRECHARGE, REG_APERTURE: return 32'h00FF_FFFF;
      REG_AZMUX_LO, REG_AZMUX_HI: return 32'h0000_000F;
      REG_PC_HI:                  return 32'h0000_0003;
      default:                    return 32'h0;   // read-only or unmapped
    endcase
  endfunction

  function automatic reg_word_t exp_read(input reg_addr_t addr);
    if (addr == REG_STATUS) return {20'h0, hw_flags_i, 8'hAA};
    if (addr == REG_SAMPLE_COUNT) return reg_word_t'(pulse_cnt);
    if (addr > REG_SAMPLE_COUNT) return 32'h0;
    return model[addr];
  endfunction

  // expected pin vector, st and mc matter only in az mode
  function automatic logic [19:0] ref_pins(input logic [2:0] mode, input logic [2:0] st,
                                           input logic mc);
    logic [3:0] mux;
    logic [1:0] pc;
    mux = '0;
    pc  = '0;
    case (mode)
      3'd0: return model[REG_DIRECT][19:0];
      3'd1: return 20'h0;
      3'd2: return 20'hF_FFFF;
      3'd3: begin
        if (st == AZ_PRECHARGE || st == AZ_SAMPLE_HI) mux = model[REG_AZMUX_HI][3:0];
        if (st == AZ_SAMPLE_LO) mux = model[REG_AZMUX_LO][3:0];
        if (st == AZ_SAMPLE_HI || st == AZ_SAMPLE_LO) pc = model[REG_PC_HI][1:0];
        return {mc, mc, mux, pc, 5'b0, st, 3'b0, st != AZ_IDLE};
      end
      default: return 20'h0;
    endcase
  endfunction

  // allowed az state steps, idle -> pre -> hi -> lo -> hi or idle
  function automatic logic state_step_ok(input logic [2:0] from_st, input logic [2:0] to_st);
    case (from_st)
      AZ_IDLE:      return to_st == AZ_PRECHARGE;
      AZ_PRECHARGE: return to_st == AZ_SAMPLE_HI;
      AZ_SAMPLE_HI: return to_st == AZ_SAMPLE_LO;
      AZ_SAMPLE_LO: return to_st == AZ_SAMPLE_HI || to_st == AZ_IDLE;
      default:      return 1'b0;
    endcase
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // helpers and spi host

  task automatic report_mismatch(input string name, input reg_word_t exp, input reg_word_t got);
    $display("CHECK FAILED t=%0t %s expected %h got %h", $time, name, exp, got);
    err_cnt++;
  endtask

  task automatic wait_clks(input int n);
    repeat (n) @(negedge clk);
  endtask

  // mode 0, bits change on sck fall, sdo taken just before sck rises
  task automatic spi_xfer(input reg_addr_t addr, input reg_word_t wdata, input int nbits,
                          output reg_word_t rdata);
    logic [40:0] frame;
    frame = {addr, wdata, 1'b0};
    rdata = '0;
    @(negedge clk);
    ss_n_i = 1'b0;
    wait_clks(HALF_SCK);
    for (int i = 0; i < nbits; i++) begin
      sdi_i = frame[40-i];
      wait_clks(HALF_SCK);
      if (i >= 8 && i < 40) rdata = {rdata[30:0], sdo_o};
      sck_i = 1'b1;
      wait_clks(HALF_SCK);
      sck_i = 1'b0;
    end
    wait_clks(HALF_SCK);
    ss_n_i = 1'b1;
    sdi_i  = 1'b0;
    wait_clks(2 * HALF_SCK);   // commit lands in here
  endtask

  task automatic write_reg(input reg_addr_t addr, input reg_word_t wdata);
    reg_word_t unused;
    spi_xfer(addr, wdata, 40, unused);
    if (field_mask(addr) != 0) model[addr] = wdata & field_mask(addr);
  endtask

  // 41 clocks, so the frame never commits
  task automatic check_read(input reg_addr_t addr);
    reg_word_t rd;
    spi_xfer(addr, 32'h0, 41, rd);
    chk_cnt++;
    if (rd !== exp_read(addr)) report_mismatch($sformatf("sdo_o read 0x%h", addr),
                                               exp_read(addr), rd);
  endtask

  task automatic check_pins(input string tag);
    chk_cnt++;
    if (pins_obs !== ref_pins(model[REG_MODE][2:0], monitor_o[2:0], meas_complete_o))
      report_mismatch({"pins ", tag},
                      ref_pins(model[REG_MODE][2:0], monitor_o[2:0], meas_complete_o),
                      pins_obs);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // az monitor, compares every cycle while enabled

  always @(negedge clk) begin
    if (az_mon_en) begin
      check_pins("az");
      if (monitor_o[2:0] != prev_st) begin
        if (!state_step_ok(prev_st, monitor_o[2:0])) begin
          $display("az state went from %0d to %0d at t=%0t, out of order",
                   prev_st, monitor_o[2:0], $time);
          err_cnt++;
        end
        prev_st = monitor_o[2:0];
      end
      gap_cnt++;
      if (meas_complete_o) begin
        if (seen_pulse && gap_cnt < int'(model[REG_APERTURE])) begin
          $display("samples only %0d cycles apart at t=%0t, aperture is %0d",
                   gap_cnt, $time, model[REG_APERTURE]);
          err_cnt++;
        end
        pulse_cnt++;
        seen_pulse = 1'b1;
        gap_cnt    = 0;
      end
    end
  end

  initial begin
    #(WDOG_TIME);
    $display("watchdog expired after %0d time units, run stuck", WDOG_TIME);
    $display("checks %0d, errors %0d", chk_cnt, err_cnt + 1);
    $display("Test FAILED");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // main sequence

  initial begin
    reg_word_t wd;
    reg_addr_t ua;
    int        n;
    int        pulses_idle;
    logic [3:0] hi_code;
    sck_i      = 1'b0;
    ss_n_i     = 1'b1;
    sdi_i      = 1'b0;
    hw_flags_i = 4'h0;
    rst_n_i    = 1'b0;
    for (int k = 0; k < 256; k++) model[k] = '0;
    wait_clks(10);
    rst_n_i = 1'b1;
    wait_clks(2);
    chk_cnt++;
    if (pins_obs !== 20'h0 || sdo_o !== 1'b0) report_mismatch("pins after reset", 0, pins_obs);

    // status with random flags
    for (int k = 0; k < 3; k++) begin
      hw_flags_i = 4'($random(seed));
      check_read(REG_STATUS);
    end

    // read-write registers, arm kept clear here
    for (int k = 1; k <= 8; k++) begin
      wd = $random(seed);
      if (reg_addr_t'(k) == REG_ARM) wd[0] = 1'b0;
      write_reg(reg_addr_t'(k), wd);
      check_read(reg_addr_t'(k));
    end
    write_reg(REG_STATUS, $random(seed));        // read-only, ignored
    check_read(REG_STATUS);
    write_reg(REG_SAMPLE_COUNT, $random(seed));
    check_read(REG_SAMPLE_COUNT);
    ua = 8'h0A + 8'($unsigned($random(seed)) % 246);   // 0x0a..0xff unmapped
    write_reg(ua, $random(seed));
    check_read(ua);

    // pin modes
    write_reg(REG_MODE, 32'(MODE_LO));
    wait_clks(4);
    check_pins("mode lo");
    write_reg(REG_MODE, 32'(MODE_HI));
    wait_clks(4);
    check_pins("mode hi");
    write_reg(REG_DIRECT, $random(seed));
    write_reg(REG_MODE, 32'(MODE_DIRECT));
    wait_clks(4);
    check_pins("mode direct");
    write_reg(REG_MODE, 32'd4 + ($unsigned($random(seed)) % 4));
    wait_clks(4);
    check_pins("mode undefined");

    // az acquisition
    hi_code = 4'($random(seed));
    write_reg(REG_PRECHARGE, 1 + ($unsigned($random(seed)) % 32));
    write_reg(REG_APERTURE, 1 + ($unsigned($random(seed)) % 40));
    write_reg(REG_AZMUX_HI, 32'(hi_code));
    write_reg(REG_AZMUX_LO, 32'(hi_code ^ 4'(1 + $unsigned($random(seed)) % 15)));
    write_reg(REG_PC_HI, 1 + ($unsigned($random(seed)) % 3));  // nonzero, differs from precharge
    write_reg(REG_MODE, 32'(MODE_AZ));
    prev_st   = AZ_IDLE;
    az_mon_en = 1'b1;
    write_reg(REG_ARM, 32'h1);
    n = 0;
    while (pulse_cnt < N_SAMPLES && n < 2000) begin
      @(negedge clk);
      n++;
    end
    if (pulse_cnt < N_SAMPLES) begin
      $display("only %0d az samples completed within 2000 cycles", pulse_cnt);
      err_cnt++;
    end

    // disarm, sequencer finishes the lo sample and parks
    write_reg(REG_ARM, 32'h0);
    n = 0;
    while (leds_o[0] && n < 2000) begin
      @(negedge clk);
      n++;
    end
    chk_cnt++;
    if (leds_o[0] || azmux_o !== 4'h0 || pc_sw_o !== 2'h0) begin
      $display("az pins not back to idle after disarm, leds %b azmux %h pc_sw %h",
               leds_o, azmux_o, pc_sw_o);
      err_cnt++;
    end
    pulses_idle = pulse_cnt;
    wait_clks(2 * int'(model[REG_APERTURE]) + 40);
    chk_cnt++;
    if (pulse_cnt != pulses_idle) report_mismatch("meas_complete_o pulses after idle",
                                                  pulses_idle, pulse_cnt);
    check_read(REG_SAMPLE_COUNT);
    az_mon_en = 1'b0;

    $display("checks %0d, errors %0d, samples %0d", chk_cnt, err_cnt, pulse_cnt);
    if (err_cnt == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== files.f ====
src/dmm_pkg.sv
src/spi_reg_decode.sv
src/adc_mock.sv
src/az_sequencer.sv
src/output_mode_mux.sv
src/dmm_fpga_top.sv
verification/tb_dmm_top.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_dmm_top
FILELIST = files.f
OBJ_DIR  = obj_dir
PASS_MSG = Test OK

.PHONY: simulate clean

simulate:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
